/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module chess_tb \
		-Mdir obj_dir -o chess_tb

run: build
	@out=$$(./obj_dir/chess_tb); echo "$$out"; \
		echo "$$out" | grep -q "Regression passed"

lint:
	verilator --lint-only --timing -f sources.f --top-module chess_tb

clean:
	rm -rf obj_dir

/* sources.f */
src/chess_pkg.sv
src/piece_offsets.sv
src/move_walker.sv
src/move_store.sv
src/move_gen_top.sv
tb/move_checker.sv
tb/chess_tb.sv

/* src/chess_pkg.sv */
package chess_pkg;

   localparam int piece_width = 4;
   localparam int board_width = 64 * piece_width;
   localparam int max_moves = 256;
   localparam int black_bit = 3;   // colour flag within a square code

   typedef logic [piece_width-1:0] piece_t;
   typedef logic [2:0] kind_t;
   typedef logic [board_width-1:0] board_t;

   // signed so a step off either edge stays visible
   typedef logic signed [4:0] coord_t;
   typedef logic signed [2:0] step_t;

   typedef logic [$clog2(max_moves)-1:0] move_index_t;
   typedef logic [$clog2(max_moves):0] move_count_t;   // 0 .. max_moves

   localparam kind_t kind_empty = 3'd0;
   localparam kind_t kind_king = 3'd1;
   localparam kind_t kind_queen = 3'd2;
   localparam kind_t kind_rook = 3'd3;
   localparam kind_t kind_bishop = 3'd4;
   localparam kind_t kind_knight = 3'd5;
   localparam kind_t kind_pawn = 3'd6;

   typedef enum logic [2:0]
   {
      walk_idle,
      walk_square,
      walk_dir_start,
      walk_ray_step,
      walk_hop_step,
      walk_next_square,
      walk_done
   } walk_state_t;

endpackage

/* src/move_gen_top.sv */
module move_gen_top (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    board_valid,
   input  chess_pkg::board_t       board_in,
   input  logic                    white_to_move_in,
   input  chess_pkg::move_index_t  move_index,
   input  logic                    clear_moves,
   output logic                    moves_ready,
   output logic                    move_ready,
   output chess_pkg::move_count_t  move_count,
   output chess_pkg::board_t       board_out,
   output logic                    capture_out,
   output logic                    white_to_move_out
);
   import chess_pkg::*;

   kind_t      piece_kind;
   logic [2:0] dir_index;
   step_t      row_step;
   step_t      col_step;
   logic [3:0] dir_count;
   logic       sliding;
   logic       clear_count;
   logic       side_white;
   logic       move_wr;
   board_t     move_board;
   logic       move_capture;

   move_walker move_walker_inst (
      .clk              (clk),
      .reset            (reset),
      .board_valid      (board_valid),
      .board_in         (board_in),
      .white_to_move_in (white_to_move_in),
      .clear_moves      (clear_moves),
      .piece_kind       (piece_kind),
      .dir_index        (dir_index),
      .row_step         (row_step),
      .col_step         (col_step),
      .dir_count        (dir_count),
      .sliding          (sliding),
      .clear_count      (clear_count),
      .side_white       (side_white),
      .move_wr          (move_wr),
      .move_board       (move_board),
      .move_capture     (move_capture),
      .moves_ready      (moves_ready)
   );

   piece_offsets piece_offsets_inst (
      .piece_kind (piece_kind),
      .dir_index  (dir_index),
      .row_step   (row_step),
      .col_step   (col_step),
      .dir_count  (dir_count),
      .sliding    (sliding)
   );

   move_store move_store_inst (
      .clk               (clk),
      .reset             (reset),
      .clear_count       (clear_count),
      .side_white        (side_white),
      .move_wr           (move_wr),
      .move_board        (move_board),
      .move_capture      (move_capture),
      .move_index        (move_index),
      .move_count        (move_count),
      .board_out         (board_out),
      .capture_out       (capture_out),
      .white_to_move_out (white_to_move_out),
      .move_ready        (move_ready)
   );

endmodule

/* src/move_store.sv */
module move_store (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    clear_count,
   input  logic                    side_white,
   input  logic                    move_wr,
   input  chess_pkg::board_t       move_board,
   input  logic                    move_capture,
   input  chess_pkg::move_index_t  move_index,
   output chess_pkg::move_count_t  move_count,
   output chess_pkg::board_t       board_out,
   output logic                    capture_out,
   output logic                    white_to_move_out,
   output logic                    move_ready
);
   import chess_pkg::*;

   logic [board_width:0] mem [max_moves];   // capture bit over board
   logic [board_width:0] rd_entry;
   move_index_t          index_r;
   logic                 side_r;
   logic                 room;

   assign room = (move_count < max_moves);

   always_ff @(posedge clk)
   begin
      if (reset || clear_count)
         move_count <= '0;
      else if (move_wr && room)
         move_count <= move_count + 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (move_wr && room)
         mem[move_index_t'(move_count)] <= {move_capture, move_board};
      rd_entry <= mem[move_index];
      index_r <= move_index;
      if (clear_count)
         side_r <= side_white;
   end

   // index held for a cycle means rd_entry matches it
   assign move_ready = (move_index == index_r);

   assign {capture_out, board_out} = rd_entry;
   assign white_to_move_out = ~side_r;   // stored boards have the other side to move

endmodule

/* src/move_walker.sv */
module move_walker (
   input  logic               clk,
   input  logic               reset,
   input  logic               board_valid,
   input  chess_pkg::board_t  board_in,
   input  logic               white_to_move_in,
   input  logic               clear_moves,
   output chess_pkg::kind_t   piece_kind,
   output logic [2:0]         dir_index,
   input  chess_pkg::step_t   row_step,
   input  chess_pkg::step_t   col_step,
   input  logic [3:0]         dir_count,
   input  logic               sliding,
   output logic               clear_count,
   output logic               side_white,
   output logic               move_wr,
   output chess_pkg::board_t  move_board,
   output logic               move_capture,
   output logic               moves_ready
);
   import chess_pkg::*;

   walk_state_t state;
   board_t      board;
   logic [5:0]  sq;          // origin, row in bits 5:3
   logic [3:0]  dir_num;
   coord_t      org_row;
   coord_t      org_col;
   coord_t      tgt_row;
   coord_t      tgt_col;
   logic [5:0]  tgt_sq;
   piece_t      sq_piece;
   piece_t      tgt_piece;
   logic        tgt_empty;
   logic        on_board;
   logic        open_target;
   board_t      edited;

   assign org_row = coord_t'({2'b00, sq[5:3]});
   assign org_col = coord_t'({2'b00, sq[2:0]});
   assign sq_piece = board[sq*piece_width +: piece_width];
   assign piece_kind = sq_piece[2:0];
   assign dir_index = dir_num[2:0];

   assign tgt_sq = {tgt_row[2:0], tgt_col[2:0]};
   assign tgt_piece = board[tgt_sq*piece_width +: piece_width];
   assign tgt_empty = (tgt_piece[2:0] == kind_empty);
   // 0..7 is the only range with the top two bits clear
   assign on_board = (tgt_row[4:3] == 2'b00) && (tgt_col[4:3] == 2'b00);
   assign open_target = on_board && (tgt_empty || tgt_piece[black_bit] == side_white);

   always_comb
   begin
      edited = board;
      edited[sq*piece_width +: piece_width] = '0;
      edited[tgt_sq*piece_width +: piece_width] = sq_piece;
   end

   // payload follows the target every cycle, move_wr qualifies it
   always_ff @(posedge clk)
   begin
      move_board <= edited;
      move_capture <= !tgt_empty;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= walk_idle;
         moves_ready <= 1'b0;
         move_wr <= 1'b0;
         clear_count <= 1'b0;
      end
      else
      begin
         move_wr <= 1'b0;
         clear_count <= 1'b0;
         case (state)
            walk_idle:
               if (board_valid)
               begin
                  board <= board_in;
                  side_white <= white_to_move_in;
                  clear_count <= 1'b1;   // restart the store count
                  sq <= 6'd0;
                  state <= walk_square;
               end
            walk_square:
            begin
               dir_num <= 4'd0;
               // skip empty, opponent and non-moving pieces
               if (piece_kind == kind_empty || sq_piece[black_bit] == side_white ||
                   dir_count == 4'd0)
                  state <= walk_next_square;
               else
                  state <= walk_dir_start;
            end
            walk_dir_start:
               if (dir_num < dir_count)
               begin
                  tgt_row <= org_row + row_step;
                  tgt_col <= org_col + col_step;
                  state <= sliding ? walk_ray_step : walk_hop_step;
               end
               else
                  state <= walk_next_square;
            walk_ray_step:
            begin
               move_wr <= open_target;
               if (open_target && tgt_empty)
               begin
                  tgt_row <= tgt_row + row_step;   // keep sliding
                  tgt_col <= tgt_col + col_step;
               end
               else
               begin
                  dir_num <= dir_num + 4'd1;
                  state <= walk_dir_start;
               end
            end
            walk_hop_step:
            begin
               move_wr <= open_target;
               dir_num <= dir_num + 4'd1;
               state <= walk_dir_start;
            end
            walk_next_square:
            begin
               sq <= sq + 6'd1;
               if (sq == 6'd63)
               begin
                  moves_ready <= 1'b1;   // last write already landed
                  state <= walk_done;
               end
               else
                  state <= walk_square;
            end
            walk_done:
               if (clear_moves)
               begin
                  moves_ready <= 1'b0;
                  state <= walk_idle;
               end
            default: state <= walk_idle;
         endcase
      end
   end

endmodule

/* src/piece_offsets.sv */
module piece_offsets (
   input  chess_pkg::kind_t piece_kind,
   input  logic [2:0]       dir_index,
   output chess_pkg::step_t row_step,
   output chess_pkg::step_t col_step,
   output logic [3:0]       dir_count,
   output logic             sliding
);
   import chess_pkg::*;

   always_comb
   begin
      {row_step, col_step} = '0;
      dir_count = 4'd0;
      sliding = 1'b0;
      case (piece_kind)
         kind_king, kind_queen:
         begin
            dir_count = 4'd8;
            sliding = (piece_kind == kind_queen);   // king takes one step
            case (dir_index)
               3'd0: {row_step, col_step} = {-3'sd1, -3'sd1};
               3'd1: {row_step, col_step} = {-3'sd1, 3'sd0};
               3'd2: {row_step, col_step} = {-3'sd1, 3'sd1};
               3'd3: {row_step, col_step} = {3'sd0, -3'sd1};
               3'd4: {row_step, col_step} = {3'sd0, 3'sd1};
               3'd5: {row_step, col_step} = {3'sd1, -3'sd1};
               3'd6: {row_step, col_step} = {3'sd1, 3'sd0};
               default: {row_step, col_step} = {3'sd1, 3'sd1};
            endcase
         end
         kind_rook:
         begin
            dir_count = 4'd4;
            sliding = 1'b1;
            case (dir_index)
               3'd0: {row_step, col_step} = {3'sd0, 3'sd1};
               3'd1: {row_step, col_step} = {3'sd0, -3'sd1};
               3'd2: {row_step, col_step} = {3'sd1, 3'sd0};
               default: {row_step, col_step} = {-3'sd1, 3'sd0};
            endcase
         end
         kind_bishop:
         begin
            dir_count = 4'd4;
            sliding = 1'b1;
            case (dir_index)
               3'd0: {row_step, col_step} = {3'sd1, 3'sd1};
               3'd1: {row_step, col_step} = {3'sd1, -3'sd1};
               3'd2: {row_step, col_step} = {-3'sd1, 3'sd1};
               default: {row_step, col_step} = {-3'sd1, -3'sd1};
            endcase
         end
         kind_knight:
         begin
            dir_count = 4'd8;
            case (dir_index)
               3'd0: {row_step, col_step} = {-3'sd2, -3'sd1};
               3'd1: {row_step, col_step} = {-3'sd1, -3'sd2};
               3'd2: {row_step, col_step} = {3'sd1, -3'sd2};
               3'd3: {row_step, col_step} = {3'sd2, -3'sd1};
               3'd4: {row_step, col_step} = {3'sd2, 3'sd1};
               3'd5: {row_step, col_step} = {3'sd1, 3'sd2};
               3'd6: {row_step, col_step} = {-3'sd1, 3'sd2};
               default: {row_step, col_step} = {-3'sd2, 3'sd1};
            endcase
         end
         kind_empty, kind_pawn: dir_count = 4'd0;   // pawns only block
         default: dir_count = 4'd0;
      endcase
   end

endmodule

/* tb/chess_tb.sv */
module chess_tb;
   import chess_pkg::*;

   localparam logic [31:0] seed = 32'hbb2a_b8c9;
   localparam int wait_limit = 4000;

   logic        clk = 1'b0;
   logic        reset = 1'b1;
   logic        board_valid = 1'b0;
   board_t      board_in = '0;
   logic        white_to_move_in = 1'b1;
   logic        clear_moves = 1'b0;
   move_index_t move_index;
   logic        moves_ready;
   logic        move_ready;
   move_count_t move_count;
   board_t      board_out;
   logic        capture_out;
   logic        white_to_move_out;

   logic            check_req = 1'b0;
   logic            check_done;
   logic [8*24-1:0] test_name;
   board_t          exp_board [max_moves];
   logic            exp_capture [max_moves];
   logic            exp_white;
   int              exp_count;
   int              tests_run;
   int              tests_bad;
   int              errors;
   int              reset_errors = 0;
   bit              timed_out = 1'b0;

   int rook_dr[4] = '{0, 0, 1, -1};
   int rook_dc[4] = '{1, -1, 0, 0};
   int bishop_dr[4] = '{1, 1, -1, -1};
   int bishop_dc[4] = '{1, -1, 1, -1};
   int knight_dr[8] = '{-2, -1, 1, 2, 2, 1, -1, -2};
   int knight_dc[8] = '{-1, -2, -2, -1, 1, 2, 2, 1};
   int edge_squares[8] = '{0, 7, 56, 63, 3, 24, 39, 60};

   move_gen_top move_gen_top_inst (.*);
   move_checker move_checker_inst (.*);

   initial forever #4 clk = ~clk;

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // reference move list, squares then directions then ray distance
   task automatic build_expected(input board_t b, input logic white);
      int         dr[8];
      int         dc[8];
      int         nd;
      int         tr;
      int         tc;
      logic [3:0] p;
      logic [3:0] t;
      board_t     nb;
      exp_count = 0;
      exp_white = ~white;
      for (int s = 0; s < 64; s++)
      begin
         p = b[s*4 +: 4];
         nd = 0;
         if (p != 4'd0 && p[3] != white)   // own piece
            case (p[2:0])
               3'd1, 3'd2:
                  for (int i = -1; i <= 1; i++)
                     for (int j = -1; j <= 1; j++)
                        if (i != 0 || j != 0)
                        begin
                           dr[nd] = i;
                           dc[nd] = j;
                           nd++;
                        end
               3'd3:
                  for (nd = 0; nd < 4; nd++)
                  begin
                     dr[nd] = rook_dr[nd];
                     dc[nd] = rook_dc[nd];
                  end
               3'd4:
                  for (nd = 0; nd < 4; nd++)
                  begin
                     dr[nd] = bishop_dr[nd];
                     dc[nd] = bishop_dc[nd];
                  end
               3'd5:
                  for (nd = 0; nd < 8; nd++)
                  begin
                     dr[nd] = knight_dr[nd];
                     dc[nd] = knight_dc[nd];
                  end
               default: nd = 0;
            endcase
         for (int d = 0; d < nd; d++)
         begin
            tr = s / 8 + dr[d];
            tc = s % 8 + dc[d];
            t = 4'd0;
            while (tr >= 0 && tr < 8 && tc >= 0 && tc < 8 && t == 4'd0)
            begin
               t = b[(tr*8+tc)*4 +: 4];
               if (t == 4'd0 || t[3] == white)
               begin
                  nb = b;
                  nb[s*4 +: 4] = 4'd0;
                  nb[(tr*8+tc)*4 +: 4] = p;
                  exp_board[exp_count] = nb;
                  exp_capture[exp_count] = (t != 4'd0);
                  exp_count++;
               end
               tr += dr[d];
               tc += dc[d];
               if (p[2:0] == 3'd1 || p[2:0] == 3'd5)
                  t = 4'hf;   // single step pieces
            end
         end
      end
   endtask

   function automatic logic [3:0] random_piece(input logic black);
      return {black, 3'($urandom_range(6, 1))};
   endfunction

   task automatic add_piece(inout board_t b, input logic [3:0] code);
      int s;
      s = $urandom_range(63);
      while (b[s*4 +: 4] != 4'd0)
         s = $urandom_range(63);
      b[s*4 +: 4] = code;
   endtask

   task automatic random_board(output board_t b);
      b = '0;
      repeat ($urandom_range(6, 1)) add_piece(b, random_piece(1'b0));
      repeat ($urandom_range(6, 1)) add_piece(b, random_piece(1'b1));
   endtask

   task automatic run_test(input board_t b, input logic white);
      int n;
      if (timed_out)
         return;
      build_expected(b, white);
      board_in = b;
      white_to_move_in = white;
      board_valid = 1'b1;
      next_cycle();
      board_valid = 1'b0;
      n = 0;
      while (!moves_ready && n < wait_limit)
      begin
         next_cycle();
         n++;
      end
      if (!moves_ready)
      begin
         $display("%0s: scan never finished, moves_ready stayed low", test_name);
         timed_out = 1'b1;
         return;
      end
      check_req = 1'b1;
      n = 0;
      while (!check_done && n < wait_limit)
      begin
         @(posedge clk);
         n++;
      end
      #1;
      check_req = 1'b0;
      if (!check_done)
      begin
         $display("%0s: checker did not finish the readback", test_name);
         timed_out = 1'b1;
         return;
      end
      clear_moves = 1'b1;
      next_cycle();
      clear_moves = 1'b0;
   endtask

   initial
   begin
      board_t b;
      void'($urandom(seed));
      repeat (8) next_cycle();
      reset = 1'b0;
      next_cycle();
      if (moves_ready !== 1'b0)
      begin
         $display("CHECK FAILED reset moves_ready: expected 0 actual %b", moves_ready);
         reset_errors++;
      end
      test_name = "empty board";
      run_test('0, 1'b1);
      b = '0;
      repeat (4) add_piece(b, 4'd6);   // white pawns only block
      repeat (4) add_piece(b, random_piece(1'b1));
      test_name = "pawns only";
      run_test(b, 1'b1);
      for (int k = 2; k <= 4; k++)
         for (int i = 0; i < 3; i++)
         begin
            b = '0;
            add_piece(b, 4'(k));
            repeat (3) add_piece(b, 4'd6);
            repeat (3) add_piece(b, random_piece(1'b1));
            $sformat(test_name, "slider kind %0d run %0d", k, i);
            run_test(b, 1'b1);
         end
      for (int i = 0; i < 8; i++)
         for (int k = 1; k <= 5; k += 4)
         begin
            b = '0;
            b[edge_squares[i]*4 +: 4] = 4'(k);
            $sformat(test_name, "kind %0d on square %0d", k, edge_squares[i]);
            run_test(b, 1'b1);
         end
      for (int i = 0; i < 5; i++)
      begin
         random_board(b);
         $sformat(test_name, "black to move %0d", i);
         run_test(b, 1'b0);
      end
      for (int i = 0; i < 50; i++)
      begin
         random_board(b);
         $sformat(test_name, "mixed %0d", i);
         run_test(b, (i % 2) == 0);
      end
      $display("%0d tests run, %0d with errors, %0d errors in all",
               tests_run, tests_bad + reset_errors, errors + reset_errors);
      if (timed_out || errors + reset_errors != 0)
         $display("Regression failed");
      else
         $display("Regression passed");
      $finish;
   end

endmodule

/* tb/move_checker.sv */
module move_checker (
   input  logic                    clk,
   input  logic                    check_req,
   input  logic [8*24-1:0]         test_name,
   input  int                      exp_count,
   input  chess_pkg::board_t       exp_board [chess_pkg::max_moves],
   input  logic                    exp_capture [chess_pkg::max_moves],
   input  logic                    exp_white,
   input  logic                    move_ready,
   input  chess_pkg::move_count_t  move_count,
   input  chess_pkg::board_t       board_out,
   input  logic                    capture_out,
   input  logic                    white_to_move_out,
   output chess_pkg::move_index_t  move_index,
   output logic                    check_done,
   output int                      tests_run,
   output int                      tests_bad,
   output int                      errors
);
   import chess_pkg::*;

   localparam int ready_limit = 16;

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // sweep the store and compare every entry with the model list
   task automatic compare_moves();
      int          bad;
      int          n;
      int          cycles;
      move_index_t prev_index;
      bad = 0;
      if (int'(move_count) != exp_count)
      begin
         $display("CHECK FAILED %0s move_count: expected %0d actual %0d",
                  test_name, exp_count, move_count);
         bad++;
      end
      n = (int'(move_count) < exp_count) ? int'(move_count) : exp_count;
      for (int i = 0; i < n; i++)
      begin
         prev_index = move_index;
         move_index = move_index_t'(i);
         #1;
         // a fresh index has no data behind it yet
         if (move_index != prev_index && move_ready !== 1'b0)
         begin
            $display("CHECK FAILED %0s move_ready at index %0d: expected 0 actual %b",
                     test_name, i, move_ready);
            bad++;
         end
         next_cycle();
         cycles = 1;
         while (!move_ready && cycles < ready_limit)
         begin
            next_cycle();
            cycles++;
         end
         if (!move_ready)
         begin
            $display("%0s: move_ready stayed low for index %0d", test_name, i);
            bad++;
         end
         else
         begin
            if (board_out !== exp_board[i])
            begin
               $display("CHECK FAILED %0s board %0d: expected %h actual %h",
                        test_name, i, exp_board[i], board_out);
               bad++;
            end
            if (capture_out !== exp_capture[i])
            begin
               $display("CHECK FAILED %0s capture %0d: expected %b actual %b",
                        test_name, i, exp_capture[i], capture_out);
               bad++;
            end
            if (white_to_move_out !== exp_white)
            begin
               $display("CHECK FAILED %0s white_to_move %0d: expected %b actual %b",
                        test_name, i, exp_white, white_to_move_out);
               bad++;
            end
         end
      end
      tests_run++;
      if (bad == 0)
         $display("%0s: ok, %0d moves", test_name, exp_count);
      else
      begin
         $display("%0s: %0d errors", test_name, bad);
         tests_bad++;
         errors += bad;
      end
   endtask

   initial
   begin
      move_index = '0;
      check_done = 1'b0;
      tests_run = 0;
      tests_bad = 0;
      errors = 0;
      forever
      begin
         @(posedge clk);   // request lines change 1 unit after the edge
         if (check_req && !check_done)
         begin
            #1;
            compare_moves();
            check_done = 1'b1;
         end
         else if (!check_req && check_done)
         begin
            #1;
            check_done = 1'b0;
         end
      end
   end

endmodule
